// File: bench/rgmii_rx_chk.sv
`timescale 1ns/1ps
`include "rgmii_defines.svh"

module rgmii_rx_chk (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      rx_valid_i,
    input logic [`RX_CREDIT_W-1:0]   credit_count_i,
    input logic [`RX_FIFO_PTR_W:0]   fill_count_i
);

    int fail_count = 0;  // failed assertions so far

    // every beat spends a credit the fifo still holds
    valid_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        rx_valid_i |-> credit_count_i != '0)
        else begin
            $error("rx_valid_o high with an empty credit counter");
            fail_count++;
        end

    credit_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
        credit_count_i <= `RX_CREDITS)
        else begin
            $error("credit counter above the reset grant");
            fail_count++;
        end

    fill_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
        fill_count_i <= `RX_FIFO_DEPTH)
        else begin
            $error("fifo fill count above its depth");
            fail_count++;
        end

    // reset empties the buffer so no beat follows a reset cycle
    quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !rx_valid_i)
        else begin
            $error("rx_valid_o high while in reset");
            fail_count++;
        end

endmodule

bind rx_credit_fifo rgmii_rx_chk rgmii_rx_chk_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .rx_valid_i    (rx_valid_o),
    .credit_count_i(credit_q),
    .fill_count_i  (count_q)
);

// File: bench/rgmii_rx_tb.sv
`timescale 1ns/1ps
`include "rgmii_defines.svh"

module rgmii_rx_tb;
    import rgmii_pkg::*;
    import frame_pkg::*;

    localparam int IFG_WORDS      = 8;  // idle words after each burst
    localparam int FRAME_BYTES    = 64 + 32 + 32 + 16 + 40 + 12 + 4;
    localparam int FRAME_COUNT    = 7;
    localparam int TIMEOUT_CYCLES = FRAME_BYTES + FRAME_COUNT * 40 + 200;
    localparam int OVF_PAYLOAD    = 40;

    logic        clk_i;
    logic        rst_i;
    logic [3:0]  rgmii_rxd_i;
    logic        rgmii_rx_ctl_i;
    logic        credit_i;
    logic        rx_valid_o;
    logic [7:0]  rx_data_o;
    logic        rx_last_o;
    logic        rx_err_o;
    logic [7:0]  drop_count_o;
    logic        link_up_o;
    speed_e      link_speed_o;
    logic        full_duplex_o;

    logic [31:0] lcg_state;
    logic [7:0]  idle_word;
    logic [7:0]  tx_q[$];   // bytes after the sfd, fcs included
    logic [7:0]  exp_q[$];  // payload as it should leave the fifo
    logic [7:0]  data_q[$];
    logic        last_q[$];
    logic        err_q[$];
    int          value_errors;
    int          other_errors;
    int          assert_errors;
    int          cycle_count;

    rgmii_rx_top rgmii_rx_top_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rgmii_rxd_i   (rgmii_rxd_i),
        .rgmii_rx_ctl_i(rgmii_rx_ctl_i),
        .credit_i      (credit_i),
        .rx_valid_o    (rx_valid_o),
        .rx_data_o     (rx_data_o),
        .rx_last_o     (rx_last_o),
        .rx_err_o      (rx_err_o),
        .drop_count_o  (drop_count_o),
        .link_up_o     (link_up_o),
        .link_speed_o  (link_speed_o),
        .full_duplex_o (full_duplex_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // bit-serial crc, lsb of each byte first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ b[i];
            r  = r >> 1;
            if (fb) begin
                r = r ^ CRC_POLY;
            end
        end
        return r;
    endfunction

    task automatic compare_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %02h actual %02h", $time, name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_speed(input string name, input speed_e act, input speed_e exp);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
        end
    endtask

    // low nibble is taken on the rising edge, high nibble on the falling edge
    task automatic drive_word(input logic [7:0] b, input logic dv, input logic er);
        @(negedge clk_i);
        #1;
        rgmii_rxd_i    = b[3:0];
        rgmii_rx_ctl_i = dv;
        @(posedge clk_i);
        #1;
        rgmii_rxd_i    = b[7:4];
        rgmii_rx_ctl_i = dv ^ er;
    endtask

    task automatic build_frame(input int len, input bit bad_fcs);
        logic [31:0] crc;
        logic [7:0]  b;
        tx_q.delete();
        exp_q.delete();
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < len; i++) begin
            b = lcg_byte();
            exp_q.push_back(b);
            tx_q.push_back(b);
            crc = crc32_byte(crc, b);
        end
        crc = ~crc;
        if (bad_fcs) begin
            crc[5] = ~crc[5];
        end
        for (int k = 0; k < 4; k++) begin
            tx_q.push_back(crc[8*k +: 8]);  // fcs goes out low byte first
        end
    endtask

    task automatic send_frame(input bit with_sfd, input int er_at);
        repeat (7) drive_word(PREAMBLE_BYTE, 1'b1, 1'b0);
        if (with_sfd) begin
            drive_word(SFD_BYTE, 1'b1, 1'b0);
        end
        foreach (tx_q[i]) begin
            drive_word(tx_q[i], 1'b1, i == er_at);
        end
        repeat (IFG_WORDS) drive_word(idle_word, 1'b0, 1'b0);
    endtask

    task automatic drive_status(input logic link, input speed_e speed, input logic duplex);
        rgmii_word_u    w;
        inband_status_t st;
        st.link     = link;
        st.speed    = speed;
        st.duplex   = duplex;
        w.status[0] = st;
        w.status[1] = st;
        idle_word   = w.data;
        repeat (6) drive_word(idle_word, 1'b0, 1'b0);
    endtask

    task automatic collect_beats(input int want, input bit give);
        int got;
        got = 0;
        while (got < want) begin
            @(posedge clk_i);
            #1 credit_i = give;
            @(negedge clk_i);
            if (rx_valid_o) begin
                data_q.push_back(rx_data_o);
                last_q.push_back(rx_last_o);
                err_q.push_back(rx_err_o);
                got++;
            end
        end
        @(posedge clk_i);
        #1 credit_i = 1'b0;
    endtask

    // counter saturates so a full grant always refills it
    task automatic restore_credits();
        repeat (`RX_CREDITS) begin
            @(posedge clk_i);
            #1 credit_i = 1'b1;
        end
        @(posedge clk_i);
        #1 credit_i = 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            if (rx_valid_o) begin
                other_errors++;
                $display("unexpected output beat at %0t with no frame due", $time);
            end
        end
    endtask

    task automatic check_beats(input int n, input bit framed, input bit exp_err);
        for (int i = 0; i < n; i++) begin
            compare_byte("rx_data_o", data_q[i], exp_q[i]);
            compare_flag("rx_last_o", last_q[i], framed && i == n - 1);
            compare_flag("rx_err_o", err_q[i], framed && i == n - 1 && exp_err);
        end
        data_q.delete();
        last_q.delete();
        err_q.delete();
    endtask

    task automatic run_frame(input int len, input bit bad_fcs, input int er_at);
        build_frame(len, bad_fcs);
        fork
            send_frame(1'b1, er_at);
            collect_beats(len, 1'b1);
        join
        restore_credits();
        check_beats(len, 1'b1, bad_fcs || er_at >= 0);
    endtask

    task automatic test_inband_status();
        drive_status(1'b1, SPEED_1000, 1'b1);
        compare_flag("link_up_o", link_up_o, 1'b1);
        compare_speed("link_speed_o", link_speed_o, SPEED_1000);
        compare_flag("full_duplex_o", full_duplex_o, 1'b1);
        drive_status(1'b0, SPEED_10, 1'b0);
        compare_flag("link_up_o", link_up_o, 1'b0);
        compare_speed("link_speed_o", link_speed_o, SPEED_10);
        compare_flag("full_duplex_o", full_duplex_o, 1'b0);
    endtask

    task automatic test_credit_flow();
        build_frame(16, 1'b0);
        fork
            send_frame(1'b1, -1);
            collect_beats(`RX_CREDITS, 1'b0);
        join
        expect_quiet(8);  // grant used up, rest waits in the fifo
        collect_beats(16 - `RX_CREDITS, 1'b1);
        restore_credits();
        check_beats(16, 1'b1, 1'b0);
    endtask

    task automatic test_overflow();
        build_frame(OVF_PAYLOAD, 1'b0);
        fork
            send_frame(1'b1, -1);
            collect_beats(`RX_CREDITS, 1'b0);
        join
        compare_byte("drop_count_o", drop_count_o,
                     8'(OVF_PAYLOAD - `RX_FIFO_DEPTH - `RX_CREDITS));
        collect_beats(`RX_FIFO_DEPTH, 1'b1);
        restore_credits();
        check_beats(`RX_FIFO_DEPTH + `RX_CREDITS, 1'b0, 1'b0);  // tail and last were dropped
    endtask

    task automatic test_bad_start();
        tx_q.delete();
        for (int i = 0; i < 12; i++) begin
            tx_q.push_back(8'hA0 + 8'(i));
        end
        fork
            send_frame(1'b0, -1);
            expect_quiet(7 + 12 + IFG_WORDS + 8);  // whole burst plus pipeline
        join
        tx_q.delete();
        repeat (4) tx_q.push_back(lcg_byte());  // runt, shorter than the fcs line
        fork
            send_frame(1'b1, -1);
            expect_quiet(8 + 4 + IFG_WORDS + 8);
        join
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("timeout after %0d cycles waiting on the DUT", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        rgmii_rxd_i    = 4'h0;
        rgmii_rx_ctl_i = 1'b0;
        credit_i       = 1'b0;
        lcg_state      = 32'd99;
        idle_word      = 8'h00;
        value_errors   = 0;
        other_errors   = 0;
        assert_errors  = 0;
        repeat (2) @(posedge clk_i);
        #1 rst_i = 1'b0;
        compare_flag("rx_valid_o", rx_valid_o, 1'b0);
        compare_flag("link_up_o", link_up_o, 1'b0);
        compare_byte("drop_count_o", drop_count_o, 8'd0);

        test_inband_status();
        run_frame(64, 1'b0, -1);  // good frame
        run_frame(32, 1'b1, -1);  // corrupted fcs
        run_frame(32, 1'b0, 10);  // rx error mid frame
        test_credit_flow();
        test_overflow();
        test_bad_start();

        assert_errors = rgmii_rx_top_inst.fifo_inst.rgmii_rx_chk_inst.fail_count;
        $display("error summary: %0d value mismatches, %0d other errors, %0d failed assertions",
                 value_errors, other_errors, assert_errors);
        if (value_errors + other_errors + assert_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: common/frame_pkg.sv
package frame_pkg;

    // framer states
    typedef enum logic [1:0] {
        ST_IDLE,      // waiting for rx valid
        ST_PREAMBLE,  // inside 0x55 run, looking for sfd
        ST_PAYLOAD,   // after sfd, crc running
        ST_DISCARD    // bad start, sit out the rest of the burst
    } framer_state_e;

    // preamble and start-of-frame delimiter bytes
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    // reflected crc-32, lsb first as bytes arrive on the wire
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;

    // register preset at the start of every frame
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    // raw register value after data plus a good fcs, no final inversion
    localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

endpackage

// File: common/rgmii_defines.svh
`ifndef RGMII_DEFINES_SVH
`define RGMII_DEFINES_SVH

// ddr lanes, rxd[3:0] first and rx_ctl on the top lane
`define RGMII_LANES 5

// receive fifo entries, kept a power of two so the pointers wrap on their own
`define RX_FIFO_DEPTH 16

// fifo pointer width, log2 of the depth
`define RX_FIFO_PTR_W 4

// credits granted to the consumer after reset
`define RX_CREDITS 4

// credit counter width, must hold RX_CREDITS
`define RX_CREDIT_W 3

// input cell flavour: "xilinx", "altera", "gowin" or "generic"
`define RGMII_VENDOR "generic"

`endif

// File: common/rgmii_pkg.sv
package rgmii_pkg;

    // speed code as sent in the in-band status nibble
    typedef enum logic [1:0] {
        SPEED_10   = 2'b00,
        SPEED_100  = 2'b01,
        SPEED_1000 = 2'b10,
        SPEED_RSVD = 2'b11
    } speed_e;

    // in-band status nibble, rxd[0] is link and rxd[3] is duplex
    typedef struct packed {
        logic   duplex;  // 1 = full duplex
        speed_e speed;
        logic   link;    // 1 = link up
    } inband_status_t;

    // one received word
    // while rx valid is high it is a frame byte; between frames, with
    // valid and error both low, each nibble carries a copy of the status
    typedef union packed {
        logic [7:0]            data;
        inband_status_t [1:0]  status;  // [0] rising nibble, [1] falling nibble
    } rgmii_word_u;

endpackage

// File: design/iddr.sv
`timescale 1ns/1ps

module iddr #(
    parameter VENDOR = "generic"
) (
    input  logic clk_i,
    input  logic d_i,
    output logic q1_o,
    output logic q2_o
);

    logic rise_q;
    logic fall_q;
    logic q1_q;
    logic q2_q;

    always_ff @(posedge clk_i) begin
        rise_q <= d_i;
    end

    always_ff @(negedge clk_i) begin
        fall_q <= d_i;  // second half of the bit pair
    end

    // pair lands together one rising edge later
    always_ff @(posedge clk_i) begin
        q1_q <= rise_q;
        q2_q <= fall_q;
    end

    assign q1_o = q1_q;
    assign q2_o = q2_q;

endmodule

// File: design/rgmii_rx_decoder.sv
`timescale 1ns/1ps
`include "rgmii_defines.svh"

module rgmii_rx_decoder (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [`RGMII_LANES-1:0] rise_i,
    input  logic [`RGMII_LANES-1:0] fall_i,
    output logic [7:0]              byte_o,
    output logic                    dv_o,
    output logic                    er_o,
    output logic                    link_up_o,
    output rgmii_pkg::speed_e       link_speed_o,
    output logic                    full_duplex_o
);
    import rgmii_pkg::*;

    localparam int CTL = `RGMII_LANES - 1;  // control lane index

    rgmii_word_u    word;
    inband_status_t status;
    logic           rx_dv;
    logic           rx_er;

    always_comb begin
        word.data = {fall_i[CTL-1:0], rise_i[CTL-1:0]};  // high nibble on fall
        status    = word.status[0];
        rx_dv     = rise_i[CTL];
        rx_er     = rise_i[CTL] ^ fall_i[CTL];  // fall carries dv xor er
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dv_o          <= 1'b0;
            er_o          <= 1'b0;
            link_up_o     <= 1'b0;
            link_speed_o  <= SPEED_10;
            full_duplex_o <= 1'b0;
        end else begin
            dv_o <= rx_dv;
            er_o <= rx_er;
            // interframe word carries the phy's link status
            if (!rx_dv && !rx_er) begin
                link_up_o     <= status.link;
                link_speed_o  <= status.speed;
                full_duplex_o <= status.duplex;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rx_dv) begin
            byte_o <= word.data;  // only frame bytes go forward
        end
    end

endmodule

// File: design/rgmii_rx_framer.sv
`timescale 1ns/1ps

module rgmii_rx_framer (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic [7:0] byte_i,
    input  logic       dv_i,
    input  logic       er_i,
    output logic       wr_en_o,
    output logic [7:0] wr_data_o,
    output logic       wr_last_o,
    output logic       wr_err_o
);
    import frame_pkg::*;

    localparam int LINE_LEN = 5;  // fcs bytes plus the held last byte

    framer_state_e state_q;
    logic [7:0]    line_q [LINE_LEN];
    logic [2:0]    fill_q;
    logic          line_full;
    logic [31:0]   crc_q;
    logic [31:0]   crc_next;
    logic          err_seen_q;

    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_next  = crc_byte(crc_q, byte_i);
    assign line_full = (fill_q == 3'(LINE_LEN));

    // delay line, [0] newest and [LINE_LEN-1] oldest
    always_ff @(posedge clk_i) begin
        if (state_q == ST_PAYLOAD && dv_i) begin
            line_q[0] <= byte_i;
            for (int i = 1; i < LINE_LEN; i++) begin
                line_q[i] <= line_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_PAYLOAD && line_full) begin
            wr_data_o <= line_q[LINE_LEN-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= ST_IDLE;
            fill_q     <= '0;
            crc_q      <= CRC_INIT;
            err_seen_q <= 1'b0;
            wr_en_o    <= 1'b0;
            wr_last_o  <= 1'b0;
            wr_err_o   <= 1'b0;
        end else begin
            wr_en_o   <= 1'b0;
            wr_last_o <= 1'b0;
            wr_err_o  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (dv_i) begin
                        state_q <= (byte_i == PREAMBLE_BYTE) ? ST_PREAMBLE : ST_DISCARD;
                    end
                end
                ST_PREAMBLE: begin
                    fill_q     <= '0;  // fresh frame state while waiting for sfd
                    crc_q      <= CRC_INIT;
                    err_seen_q <= 1'b0;
                    if (!dv_i) begin
                        state_q <= ST_IDLE;
                    end else if (byte_i == SFD_BYTE) begin
                        state_q <= ST_PAYLOAD;
                    end else if (byte_i != PREAMBLE_BYTE) begin
                        state_q <= ST_DISCARD;
                    end
                end
                ST_PAYLOAD: begin
                    if (dv_i) begin
                        crc_q      <= crc_next;
                        err_seen_q <= err_seen_q | er_i;
                        if (line_full) begin
                            wr_en_o <= 1'b1;  // oldest byte cannot be fcs any more
                        end else begin
                            fill_q <= fill_q + 3'd1;
                        end
                    end else begin
                        // runts never fill the line and vanish here
                        if (line_full) begin
                            wr_en_o   <= 1'b1;
                            wr_last_o <= 1'b1;
                            wr_err_o  <= (crc_q != CRC_RESIDUE) || err_seen_q;
                        end
                        state_q <= ST_IDLE;
                    end
                end
                ST_DISCARD: begin
                    if (!dv_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: design/rgmii_rx_top.sv
`timescale 1ns/1ps
`include "rgmii_defines.svh"

module rgmii_rx_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic [3:0]        rgmii_rxd_i,
    input  logic              rgmii_rx_ctl_i,
    input  logic              credit_i,
    output logic              rx_valid_o,
    output logic [7:0]        rx_data_o,
    output logic              rx_last_o,
    output logic              rx_err_o,
    output logic [7:0]        drop_count_o,
    output logic              link_up_o,
    output rgmii_pkg::speed_e link_speed_o,
    output logic              full_duplex_o
);

    logic [`RGMII_LANES-1:0] pin_d;
    logic [`RGMII_LANES-1:0] lane_rise;
    logic [`RGMII_LANES-1:0] lane_fall;
    logic [7:0]              dec_byte;
    logic                    dec_dv;
    logic                    dec_er;
    logic                    fr_wr_en;
    logic [7:0]              fr_wr_data;
    logic                    fr_wr_last;
    logic                    fr_wr_err;

    assign pin_d = {rgmii_rx_ctl_i, rgmii_rxd_i};  // ctl on the top lane

    generate
        for (genvar i = 0; i < `RGMII_LANES; i++) begin : g_lane
            iddr #(
                .VENDOR(`RGMII_VENDOR)
            ) iddr_inst (
                .clk_i(clk_i),
                .d_i  (pin_d[i]),
                .q1_o (lane_rise[i]),
                .q2_o (lane_fall[i])
            );
        end
    endgenerate

    rgmii_rx_decoder decoder_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rise_i       (lane_rise),
        .fall_i       (lane_fall),
        .byte_o       (dec_byte),
        .dv_o         (dec_dv),
        .er_o         (dec_er),
        .link_up_o    (link_up_o),
        .link_speed_o (link_speed_o),
        .full_duplex_o(full_duplex_o)
    );

    rgmii_rx_framer framer_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .byte_i   (dec_byte),
        .dv_i     (dec_dv),
        .er_i     (dec_er),
        .wr_en_o  (fr_wr_en),
        .wr_data_o(fr_wr_data),
        .wr_last_o(fr_wr_last),
        .wr_err_o (fr_wr_err)
    );

    rx_credit_fifo fifo_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_en_i     (fr_wr_en),
        .wr_data_i   (fr_wr_data),
        .wr_last_i   (fr_wr_last),
        .wr_err_i    (fr_wr_err),
        .credit_i    (credit_i),
        .rx_valid_o  (rx_valid_o),
        .rx_data_o   (rx_data_o),
        .rx_last_o   (rx_last_o),
        .rx_err_o    (rx_err_o),
        .drop_count_o(drop_count_o)
    );

endmodule

// File: design/rx_credit_fifo.sv
`timescale 1ns/1ps
`include "rgmii_defines.svh"

module rx_credit_fifo (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       wr_en_i,
    input  logic [7:0] wr_data_i,
    input  logic       wr_last_i,
    input  logic       wr_err_i,
    input  logic       credit_i,
    output logic       rx_valid_o,
    output logic [7:0] rx_data_o,
    output logic       rx_last_o,
    output logic       rx_err_o,
    output logic [7:0] drop_count_o
);

    localparam int PTR_W = `RX_FIFO_PTR_W;
    localparam int CRD_W = `RX_CREDIT_W;
    localparam logic [PTR_W:0]   DEPTH       = `RX_FIFO_DEPTH;
    localparam logic [CRD_W-1:0] MAX_CREDITS = `RX_CREDITS;

    logic [9:0]       mem_q [`RX_FIFO_DEPTH];  // {err, last, data}
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic [CRD_W-1:0] credit_q;
    logic             full;
    logic             empty;
    logic             wr_ok;
    logic             beat;

    assign full  = (count_q == DEPTH);
    assign empty = (count_q == '0);
    assign wr_ok = wr_en_i && !full;
    assign beat  = !empty && (credit_q != '0);  // one beat costs one credit

    assign rx_valid_o = beat;
    assign {rx_err_o, rx_last_o, rx_data_o} = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem_q[wr_ptr_q] <= {wr_err_i, wr_last_i, wr_data_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            credit_q     <= MAX_CREDITS;
            drop_count_o <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps at depth
            end
            if (beat) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_ok, beat})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
            // beat and returned credit together cancel
            case ({beat, credit_i})
                2'b10: credit_q <= credit_q - 1'b1;
                2'b01: begin
                    if (credit_q != MAX_CREDITS) begin
                        credit_q <= credit_q + 1'b1;
                    end
                end
                default: ;
            endcase
            if (wr_en_i && full && drop_count_o != 8'hFF) begin
                drop_count_o <= drop_count_o + 8'd1;  // line side never waits
            end
        end
    end

endmodule

// File: rgmii_rx_top.f
+incdir+common
common/rgmii_pkg.sv
common/frame_pkg.sv
design/iddr.sv
design/rgmii_rx_decoder.sv
design/rgmii_rx_framer.sv
design/rx_credit_fifo.sv
design/rgmii_rx_top.sv
bench/rgmii_rx_chk.sv
bench/rgmii_rx_tb.sv
